//--- project.f
verilog/pit_reg_pkg.sv
verilog/pit_timing_pkg.sv
verilog/pit_counter_if.sv
verilog/pit_clock_gen.sv
verilog/pit_counter.sv
verilog/pit.sv
verilog/pit_wb_slave.sv
verilog/pit_top.sv
testbench/pit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, then scan the log for a failure

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module pit_tb -f project.f -o pit_sim \
    && ./obj_dir/pit_sim | tee sim.log \
    || { echo "build or simulation run did not complete"; exit 1; }

grep -q "Simulation FAILED" sim.log && { echo "test run failed"; exit 1; } \
    || { echo "test run clean"; exit 0; }

//--- testbench/pit_tb.sv
`timescale 1ns/1ps

module pit_tb;
    import pit_reg_pkg::*;
    import pit_timing_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int TICK_CLKS     = 4;                                // CLK_HZ / PIT_HZ
    localparam int SEED          = 39540;
    localparam int REFRESH_READS = REFRESH_TICKS * TICK_CLKS;      // each read spans 2+ clocks
    localparam int WORST_CLKS    = 3 * 2                           // reset
                                 + 20 * 3 + 2 * TICK_CLKS + 2      // latch and read-back
                                 + 3 * 3 + 43 * TICK_CLKS          // mode 0 with n up to 40
                                 + 4 * 3 + 3 * 2 * 40 + 8          // square wave over three edges
                                 + 8 * 6 + (REFRESH_READS + 1) * 3 // speaker port sweep
                                 + 12 * 3 + 4 * TICK_CLKS + 6 * 299;  // counter 1 up to 299
    localparam int MARGIN_CLKS   = 500;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    pit_addr_t   wb_adr;
    pit_byte_t   wb_dat_w;
    pit_byte_t   wb_dat_r;
    logic        wb_ack;
    logic        irq;
    logic        speaker_enable;
    logic        speaker_out;
    int          errors;
    int          checks;
    pit_access_t model_acc [3];  // access field per counter
    pit_count_t  model_cnt [3];  // count as the counter should see it
    logic [1:0]  model_spk;      // enable and gate

    pit_top #(.CLK_HZ(4), .PIT_HZ(1)) dut_i (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .irq(irq), .speaker_enable(speaker_enable), .speaker_out(speaker_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------------------------
    // bus access and check helpers

    task automatic wb_access(input logic we, input pit_addr_t addr, input pit_byte_t wdat,
                             output pit_byte_t rdat);
        @(negedge clk);  // one idle clock between cycles
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdat;
        do begin
            @(negedge clk);
        end while (!wb_ack);  // held until ack
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input pit_addr_t addr, input pit_byte_t data);
        pit_byte_t unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input pit_addr_t addr, output pit_byte_t data);
        wb_access(1'b0, addr, 8'h00, data);
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0d ns: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    // control word followed by the count bytes the access field asks for
    task automatic program_counter(input int idx, input pit_mode_t mode,
                                   input pit_access_t acc, input pit_count_t cnt);
        wb_write(ADDR_CONTROL, {2'(idx), acc, mode, 1'b0});
        if (acc != ACC_MSB)
            wb_write(pit_addr_t'(idx), cnt[7:0]);   // counter address equals index
        if (acc != ACC_LSB)
            wb_write(pit_addr_t'(idx), cnt[15:8]);
        model_acc[idx] = acc;
        case (acc)
            ACC_LSB: model_cnt[idx] = {8'h00, cnt[7:0]};
            ACC_MSB: model_cnt[idx] = {cnt[15:8], 8'h00};
            default: model_cnt[idx] = cnt;
        endcase
    endtask

    task automatic read_count(input int idx, output pit_count_t value);
        pit_byte_t lo;
        pit_byte_t hi;
        lo = 8'h00;
        hi = 8'h00;
        if (model_acc[idx] != ACC_MSB)
            wb_read(pit_addr_t'(idx), lo);  // low byte first in word access
        if (model_acc[idx] != ACC_LSB)
            wb_read(pit_addr_t'(idx), hi);
        value = {hi, lo};
    endtask

    task automatic wait_speaker_edge(output int clks);
        logic prev;
        prev = speaker_out;
        clks = 0;
        do begin
            @(negedge clk);
            clks++;
        end while (speaker_out === prev);
    endtask

    // ----------------------------------------------------------
    // test sequence

    initial begin
        int          n;
        int          sel;
        int          clks;
        pit_mode_t   mode;
        pit_access_t acc;
        pit_count_t  cnt;
        pit_count_t  c1;
        pit_count_t  c2;
        pit_byte_t   rdat;
        logic        first_refresh;
        logic        refresh_seen;
        void'($urandom(SEED));
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        errors   = 0;
        checks   = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // latched count with the gate low so the count holds
        wb_write(ADDR_SPEAKER, 8'h00);
        model_spk = 2'b00;
        sel  = $urandom % 3;
        mode = (sel == 0) ? 3'd0 : pit_mode_t'(sel + 1);        // 0, 2 or 3
        acc  = pit_access_t'(1 + $urandom % 3);
        cnt  = pit_count_t'($urandom);
        if (mode == 3'd3)
            cnt[0] = 1'b0;                                      // square wave counts even
        program_counter(2, mode, acc, cnt);
        repeat (2 * TICK_CLKS + 2) @(negedge clk);
        wb_write(ADDR_CONTROL, {2'd2, ACC_LATCH, 4'h0});
        read_count(2, c1);
        check_equal(c1, model_cnt[2], "counter 2 latched count");

        // read-back status followed by read-back count
        wb_write(ADDR_CONTROL, 8'b1110_1000);                   // status of counter 2
        wb_read(ADDR_COUNTER2, rdat);
        check_equal(rdat, {mode != 3'd0, 1'b0, acc, mode, 1'b0}, "counter 2 status byte");
        wb_write(ADDR_CONTROL, 8'b1101_1000);                   // count of counter 2
        read_count(2, c1);
        check_equal(c1, model_cnt[2], "counter 2 read-back count");

        // mode 0 on counter 0 drives irq
        n = 4 + $urandom % 37;
        program_counter(0, 3'd0, ACC_WORD, pit_count_t'(n));
        repeat ((n - 1) * TICK_CLKS) @(negedge clk);
        check_equal(irq, 1'b0, "irq before terminal count");
        repeat (3 * TICK_CLKS) @(negedge clk);
        check_equal(irq, 1'b1, "irq after terminal count");

        // mode 3 square wave on the speaker
        n = 2 * (2 + $urandom % 19);                            // even from 4 to 40
        program_counter(2, 3'd3, ACC_WORD, pit_count_t'(n));
        wb_write(ADDR_SPEAKER, 8'h03);
        model_spk = 2'b11;
        wait_speaker_edge(clks);                                // first half period is partial
        repeat (2) begin
            wait_speaker_edge(clks);
            check_equal(clks, 2 * n, "speaker_out half period in clocks");
        end

        // speaker port bits and refresh toggle
        for (int i = 0; i < 8; i++) begin
            cnt[7:0] = pit_byte_t'($urandom);
            wb_write(ADDR_SPEAKER, cnt[7:0]);
            model_spk = cnt[1:0];
            check_equal(speaker_enable, model_spk[1], "speaker_enable pin");
            wb_read(ADDR_SPEAKER, rdat);
            check_equal(rdat[1:0], model_spk, "speaker port bits 1:0");
            check_equal({rdat[7:6], rdat[3:2]}, 4'h0, "speaker port zero bits");
        end
        wb_read(ADDR_SPEAKER, rdat);
        first_refresh = rdat[4];
        refresh_seen  = 1'b0;
        for (int i = 0; i < REFRESH_READS; i++) begin
            wb_read(ADDR_SPEAKER, rdat);
            if (rdat[4] !== first_refresh)
                refresh_seen = 1'b1;
        end
        check_equal(refresh_seen, 1'b1, "refresh toggle change");

        // control address and free running counter 1
        wb_read(ADDR_CONTROL, rdat);
        check_equal(rdat, 8'h00, "control address read");
        n = 20 + $urandom % 280;
        program_counter(1, 3'd2, ACC_WORD, pit_count_t'(n));
        repeat (4 * TICK_CLKS) @(negedge clk);                  // count loaded by now
        wb_write(ADDR_CONTROL, {2'd1, ACC_LATCH, 4'h0});
        read_count(1, c1);
        repeat (6 * n) @(negedge clk);                          // about 1.5 reload periods
        wb_write(ADDR_CONTROL, {2'd1, ACC_LATCH, 4'h0});
        read_count(1, c2);
        check_equal(c1 >= 1 && c1 <= n, 1'b1, "counter 1 first latch in 1..N");
        check_equal(c2 >= 1 && c2 <= n, 1'b1, "counter 1 second latch in 1..N");
        check_equal(c1 != c2, 1'b1, "counter 1 latches differ");

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // watchdog sized from the worst case of every test
    initial begin
        #((WORST_CLKS + MARGIN_CLKS) * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d clocks", WORST_CLKS + MARGIN_CLKS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- verilog/pit.sv
`timescale 1ns/1ps

module pit #(
    parameter int CLK_HZ = pit_timing_pkg::DEFAULT_CLK_HZ,
    parameter int PIT_HZ = pit_timing_pkg::DEFAULT_PIT_HZ
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pit_reg_pkg::pit_addr_t io_address,
    input  logic                   io_read,
    input  logic                   io_write,
    input  pit_reg_pkg::pit_byte_t io_writedata,
    output pit_reg_pkg::pit_byte_t io_readdata,
    output logic                   irq,
    output logic                   speaker_enable,
    output logic                   speaker_out
);
    import pit_reg_pkg::*;
    import pit_timing_pkg::*;

    localparam int REFRESH_W = $clog2(REFRESH_TICKS);
    localparam logic [8:0] CNT_ADDR = {ADDR_COUNTER2, ADDR_COUNTER1, ADDR_COUNTER0};

    logic                    tick;
    logic                    speaker_gate;
    logic                    refresh_toggle;
    logic [REFRESH_W-1:0]    refresh_cnt;
    logic                    ctl_wr;     // control word write
    logic                    readback;   // control word is a read-back command
    logic [NUM_COUNTERS-1:0] cnt_gate;
    logic [NUM_COUNTERS-1:0] cnt_out;
    pit_byte_t               cnt_rdata [NUM_COUNTERS];

    assign ctl_wr      = io_write && io_address == ADDR_CONTROL;
    assign readback    = io_writedata[7:6] == CW_SEL_READBACK;
    assign cnt_gate    = {speaker_gate, 2'b11};  // counters 0 and 1 always enabled
    assign irq         = cnt_out[0];
    assign speaker_out = cnt_out[2];

    pit_clock_gen #(
        .CLK_HZ (CLK_HZ),
        .PIT_HZ (PIT_HZ)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    // ----------------------------------------------------------
    // per counter strobe decode

    for (genvar i = 0; i < NUM_COUNTERS; i++) begin : g_cnt
        pit_counter_if cif ();

        assign cif.data_in          = io_writedata;
        assign cif.write            = io_write && io_address == CNT_ADDR[i*3 +: 3];
        assign cif.read             = io_read && io_address == CNT_ADDR[i*3 +: 3];
        assign cif.set_control_mode = ctl_wr && io_writedata[7:6] == 2'(i)
                                      && io_writedata[5:4] != ACC_LATCH;
        assign cif.latch_count      = ctl_wr && ((io_writedata[7:6] == 2'(i)
                                      && io_writedata[5:4] == ACC_LATCH)
                                      || (readback && !io_writedata[5] && io_writedata[i+1]));
        assign cif.latch_status     = ctl_wr && readback && !io_writedata[4] && io_writedata[i+1];
        assign cnt_rdata[i]         = cif.data_out;

        pit_counter u_counter (
            .clk   (clk),
            .rst_n (rst_n),
            .tick  (tick),
            .gate  (cnt_gate[i]),
            .out   (cnt_out[i]),
            .bus   (cif.counter_side)
        );
    end

    // ----------------------------------------------------------
    // speaker port and refresh toggle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            speaker_gate   <= 1'b0;
            speaker_enable <= 1'b0;
        end else if (io_write && io_address == ADDR_SPEAKER) begin
            speaker_gate   <= io_writedata[0];  // gate of counter 2
            speaker_enable <= io_writedata[1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_cnt    <= '0;
            refresh_toggle <= 1'b0;
        end else if (tick) begin
            if (refresh_cnt == REFRESH_W'(REFRESH_TICKS - 1)) begin
                refresh_cnt    <= '0;
                refresh_toggle <= ~refresh_toggle;
            end else begin
                refresh_cnt <= refresh_cnt + 1'b1;
            end
        end
    end

    // registered read mux, data valid the clock after io_read
    always_ff @(posedge clk) begin
        if (io_read) begin
            case (io_address)
                ADDR_COUNTER0: io_readdata <= cnt_rdata[0];
                ADDR_COUNTER1: io_readdata <= cnt_rdata[1];
                ADDR_COUNTER2: io_readdata <= cnt_rdata[2];
                ADDR_SPEAKER:  io_readdata <= {2'b00, speaker_out, refresh_toggle,
                                               2'b00, speaker_enable, speaker_gate};
                default:       io_readdata <= '0;  // control word reads as zero
            endcase
        end
    end

endmodule

//--- verilog/pit_clock_gen.sv
`timescale 1ns/1ps

module pit_clock_gen #(
    parameter int CLK_HZ = pit_timing_pkg::DEFAULT_CLK_HZ,
    parameter int PIT_HZ = pit_timing_pkg::DEFAULT_PIT_HZ
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);
    import pit_timing_pkg::*;

    pit_acc_t acc;      // fractional phase
    pit_acc_t acc_sum;  // phase after this clock

    assign acc_sum = acc + pit_acc_t'(PIT_HZ);

    // one tick per CLK_HZ worth of accumulated PIT_HZ
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc  <= '0;
            tick <= 1'b0;
        end else if (acc_sum >= pit_acc_t'(CLK_HZ)) begin
            acc  <= acc_sum - pit_acc_t'(CLK_HZ);  // keep the remainder
            tick <= 1'b1;
        end else begin
            acc  <= acc_sum;
            tick <= 1'b0;
        end
    end

endmodule

//--- verilog/pit_counter.sv
`timescale 1ns/1ps

module pit_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tick,    // counting clock enable
    input  logic                gate,
    output logic                out,
    pit_counter_if.counter_side bus
);
    import pit_reg_pkg::*;

    typedef enum logic {WR_LSB, WR_MSB} wr_state_t;
    typedef enum logic {RD_LSB, RD_MSB} rd_state_t;

    pit_access_t access;          // RW field
    pit_mode_t   mode;            // stored as written
    logic        bcd;             // status only
    pit_count_t  count_reg;       // host written count
    pit_count_t  count_elem;      // counting element
    pit_count_t  count_latch;     // output latch
    logic        count_latched;
    pit_byte_t   status_latch;
    logic        status_latched;
    logic        null_count;
    logic        load_pending;    // complete count waiting for a tick
    logic        counting;        // element holds a valid count
    wr_state_t   wr_state;
    rd_state_t   rd_state;
    logic        is_m2;
    logic        is_m3;
    logic        at_end;
    logic        write_done;
    logic        run;
    pit_count_t  reload_val;
    pit_count_t  read_src;

    assign is_m2      = mode[1:0] == 2'b10;  // modes 2 and 6
    assign is_m3      = mode[1:0] == 2'b11;  // modes 3 and 7
    assign reload_val = is_m3 ? {count_reg[15:1], 1'b0} : count_reg;  // mode 3 counts even
    assign at_end     = is_m3 ? (count_elem == 16'd2) : (count_elem == 16'd1);
    assign write_done = bus.write && (access != ACC_WORD || wr_state == WR_MSB);
    assign run        = tick && counting && gate && !load_pending;

    // ----------------------------------------------------------
    // read path, status before latched count before live count

    always_comb begin
        read_src = count_latched ? count_latch : count_elem;
        if (status_latched)
            bus.data_out = status_latch;
        else if (access == ACC_MSB || (access == ACC_WORD && rd_state == RD_MSB))
            bus.data_out = read_src[15:8];
        else
            bus.data_out = read_src[7:0];
    end

    // ----------------------------------------------------------
    // control state

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            access         <= ACC_LSB;
            mode           <= '0;
            bcd            <= 1'b0;
            out            <= 1'b0;
            null_count     <= 1'b0;
            load_pending   <= 1'b0;
            counting       <= 1'b0;
            count_latched  <= 1'b0;
            status_latched <= 1'b0;
            wr_state       <= WR_LSB;
            rd_state       <= RD_LSB;
        end else if (bus.set_control_mode) begin
            access        <= pit_access_t'(bus.data_in[5:4]);
            mode          <= bus.data_in[3:1];
            bcd           <= bus.data_in[0];
            out           <= bus.data_in[2];  // high for 2/3/6/7, low otherwise
            null_count    <= 1'b1;
            load_pending  <= 1'b0;
            counting      <= 1'b0;            // halt until a new count
            count_latched <= 1'b0;
            wr_state      <= WR_LSB;
            rd_state      <= RD_LSB;
        end else begin
            if (tick && load_pending) begin
                load_pending <= 1'b0;  // count moves into the element
                null_count   <= 1'b0;
                counting     <= 1'b1;
            end else if (run && at_end) begin
                out <= is_m3 ? ~out : !is_m2;  // toggle, low pulse, or terminal count
            end else if (run && is_m2) begin
                out <= 1'b1;                   // end of the one tick low pulse
            end
            if (bus.write && access == ACC_WORD)
                wr_state <= (wr_state == WR_LSB) ? WR_MSB : WR_LSB;
            if (write_done) begin
                load_pending <= 1'b1;
                null_count   <= 1'b1;
            end
            if (bus.latch_count)
                count_latched <= 1'b1;         // repeat latch keeps the first value
            if (bus.latch_status)
                status_latched <= 1'b1;
            if (bus.read) begin
                if (status_latched) begin
                    status_latched <= 1'b0;    // status goes out in one byte
                end else begin
                    if (access == ACC_WORD)
                        rd_state <= (rd_state == RD_LSB) ? RD_MSB : RD_LSB;
                    if (access != ACC_WORD || rd_state == RD_MSB)
                        count_latched <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // count payload

    always_ff @(posedge clk) begin
        if (bus.write) begin
            case (access)
                ACC_LSB: count_reg <= {8'h00, bus.data_in};
                ACC_MSB: count_reg <= {bus.data_in, 8'h00};
                default: begin
                    if (wr_state == WR_LSB)
                        count_reg[7:0] <= bus.data_in;
                    else
                        count_reg[15:8] <= bus.data_in;
                end
            endcase
        end
        if (tick && load_pending)
            count_elem <= reload_val;
        else if (run)
            count_elem <= (at_end && (is_m2 || is_m3)) ? reload_val
                                                       : count_elem - (is_m3 ? 16'd2 : 16'd1);
        if (bus.latch_count && !count_latched)
            count_latch <= count_elem;
        if (bus.latch_status && !status_latched)
            status_latch <= {out, null_count, access, mode, bcd};
    end

endmodule

//--- verilog/pit_counter_if.sv
`timescale 1ns/1ps

interface pit_counter_if;
    import pit_reg_pkg::*;

    pit_byte_t data_in;           // host write byte
    logic      write;             // count register write strobe
    logic      read;              // count or status read strobe
    logic      set_control_mode;  // control word for this counter
    logic      latch_count;       // latch command or read-back count
    logic      latch_status;      // read-back status
    pit_byte_t data_out;          // byte for the current read step

    modport timer_side (
        output data_in, write, read,
        output set_control_mode, latch_count, latch_status,
        input  data_out
    );

    modport counter_side (
        input  data_in, write, read,
        input  set_control_mode, latch_count, latch_status,
        output data_out
    );

endinterface

//--- verilog/pit_reg_pkg.sv
package pit_reg_pkg;

    // ----------------------------------------------------------
    // register level types

    typedef logic [7:0]  pit_byte_t;   // one host byte
    typedef logic [15:0] pit_count_t;  // counter value
    typedef logic [2:0]  pit_addr_t;   // register address
    typedef logic [2:0]  pit_mode_t;   // M2..M0 of the control word

    // RW field of the control word, bits 5:4
    typedef enum logic [1:0] {
        ACC_LATCH = 2'b00,             // counter latch command
        ACC_LSB   = 2'b01,             // low byte only
        ACC_MSB   = 2'b10,             // high byte only
        ACC_WORD  = 2'b11              // low byte then high byte
    } pit_access_t;

    localparam int NUM_COUNTERS = 3;

    // SC field value that turns the control word into read-back
    localparam logic [1:0] CW_SEL_READBACK = 2'b11;

    // ----------------------------------------------------------
    // io address map

    localparam pit_addr_t ADDR_COUNTER0 = 3'd0;
    localparam pit_addr_t ADDR_COUNTER1 = 3'd1;
    localparam pit_addr_t ADDR_COUNTER2 = 3'd2;
    localparam pit_addr_t ADDR_CONTROL  = 3'd3;  // write only
    localparam pit_addr_t ADDR_SPEAKER  = 3'd4;  // speaker port, like 61h

endpackage

//--- verilog/pit_timing_pkg.sv
package pit_timing_pkg;

    // tick accumulator, wide enough for clk rate plus tick rate
    typedef logic [31:0] pit_acc_t;

    // system clock, overridden from the top level
    localparam int DEFAULT_CLK_HZ = 50_000_000;

    // classic pc timer input rate
    localparam int DEFAULT_PIT_HZ = 1_193_182;

    // ticks between flips of the refresh toggle bit
    localparam int REFRESH_TICKS = 18;

endpackage

//--- verilog/pit_top.sv
`timescale 1ns/1ps

module pit_top #(
    parameter int CLK_HZ = pit_timing_pkg::DEFAULT_CLK_HZ,
    parameter int PIT_HZ = pit_timing_pkg::DEFAULT_PIT_HZ
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  pit_reg_pkg::pit_addr_t wb_adr,
    input  pit_reg_pkg::pit_byte_t wb_dat_w,
    output pit_reg_pkg::pit_byte_t wb_dat_r,
    output logic                   wb_ack,
    output logic                   irq,             // counter 0 out
    output logic                   speaker_enable,
    output logic                   speaker_out      // counter 2 out
);
    import pit_reg_pkg::*;

    pit_addr_t io_address;
    pit_byte_t io_writedata;
    pit_byte_t io_readdata;
    logic      io_read;
    logic      io_write;

    pit_wb_slave u_wb_slave (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .io_address   (io_address),
        .io_read      (io_read),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .io_readdata  (io_readdata)
    );

    pit #(
        .CLK_HZ (CLK_HZ),
        .PIT_HZ (PIT_HZ)
    ) u_pit (
        .clk            (clk),
        .rst_n          (rst_n),
        .io_address     (io_address),
        .io_read        (io_read),
        .io_write       (io_write),
        .io_writedata   (io_writedata),
        .io_readdata    (io_readdata),
        .irq            (irq),
        .speaker_enable (speaker_enable),
        .speaker_out    (speaker_out)
    );

endmodule

//--- verilog/pit_wb_slave.sv
`timescale 1ns/1ps

module pit_wb_slave (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  pit_reg_pkg::pit_addr_t wb_adr,
    input  pit_reg_pkg::pit_byte_t wb_dat_w,
    output pit_reg_pkg::pit_byte_t wb_dat_r,
    output logic                   wb_ack,
    output pit_reg_pkg::pit_addr_t io_address,
    output logic                   io_read,
    output logic                   io_write,
    output pit_reg_pkg::pit_byte_t io_writedata,
    input  pit_reg_pkg::pit_byte_t io_readdata
);
    typedef enum logic {IDLE, ACK} state_t;

    state_t state;
    logic   start;  // new cycle seen while idle

    assign start    = state == IDLE && wb_cyc && wb_stb;
    assign wb_dat_r = io_readdata;  // timer already registers it

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            io_read  <= 1'b0;
            io_write <= 1'b0;
            wb_ack   <= 1'b0;
        end else begin
            io_read  <= start && !wb_we;  // single clock strobes
            io_write <= start && wb_we;
            case (state)
                IDLE: begin
                    if (start)
                        state <= ACK;
                end
                ACK: begin
                    wb_ack <= !wb_ack;    // one cycle high, then back to idle
                    if (wb_ack)
                        state <= IDLE;
                end
            endcase
        end
    end

    // address and write data held for the strobe
    always_ff @(posedge clk) begin
        if (start) begin
            io_address   <= wb_adr;
            io_writedata <= wb_dat_w;
        end
    end

endmodule
